// File: src/mipsPkg.sv
package mipsPkg;

    localparam logic [2:0] tuseNone = 3'd5;  // Operand not read.
    localparam logic [1:0] tnewMax  = 2'd3;  // Load result, latest producer.
    localparam logic [4:0] regZero  = 5'd0;
    localparam logic [4:0] regRa    = 5'd31; // Link register for jal.

    // Primary opcode field, instr[31:26].
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opJal     = 6'h03,
        opBeq     = 6'h04,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcodeE;

    // Funct field of special instructions, instr[5:0].
    typedef enum logic [5:0] {
        opJr   = 6'h08,
        opAddu = 6'h21,
        opSubu = 6'h23
    } functE;

    typedef enum logic [2:0] {
        aluNone,
        aluAdd,
        aluSub,
        aluOr,
        aluLui
    } aluOpE;

    typedef enum logic {
        cmpNone,
        cmpEq
    } cmpOpE;

    typedef enum logic [1:0] {
        npcSeq,
        npcBranch,
        npcJump,
        npcJr
    } npcOpE;

    typedef enum logic [2:0] {
        clsNop,
        clsCal,
        clsLoad,
        clsSave,
        clsCmpJump,
        clsJumpJJal,
        clsJumpJr
    } instrClassE;

    typedef enum logic [1:0] {
        wrRt,
        wrRd,
        wrRa
    } wrSelE;

    typedef enum logic [1:0] {
        wdAlu,
        wdMem,
        wdPc8
    } wdSelE;

    typedef enum logic [1:0] {
        fwdNone,
        fwdE,
        fwdM,
        fwdW
    } fwdSelE;

    typedef struct packed {
        npcOpE      npcOp;
        wrSelE      wrSel;
        wdSelE      wdSel;
        logic       rfWe;
        logic       extOp;   // Sign extend when set.
        cmpOpE      cmpOp;
        logic       aSel;
        logic       bSel;    // Immediate as ALU operand B.
        aluOpE      aluOp;
        logic       dmWe;
        logic [1:0] dmType;
        instrClassE instrClass;
    } ctrlT;

    typedef struct packed {
        logic [2:0] tuseRs;
        logic [2:0] tuseRt;
        logic [1:0] tnew;
        logic [4:0] dstReg;  // Zero when nothing is written.
    } hazT;

    typedef struct packed {
        logic [4:0] dstReg;
        logic [1:0] tnew;
    } writerT;

endpackage

// File: src/instrDecoder.sv
`timescale 1ns/10ps

module instrDecoder (
    input  logic [31:0]   instr,
    output mipsPkg::ctrlT ctrl,
    output mipsPkg::hazT  hz
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [2:0] tuseRs;
    logic [2:0] tuseRt;
    logic [1:0] tnew;
    logic [4:0] dstReg;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];

    always_comb begin
        ctrl   = '0;  // Default covers nop and unknown words.
        tuseRs = mipsPkg::tuseNone;
        tuseRt = mipsPkg::tuseNone;
        tnew   = 2'd0;
        case (opcode)
            mipsPkg::opSpecial: begin
                case (funct)
                    mipsPkg::opAddu: begin
                        ctrl.wrSel      = mipsPkg::wrRd;
                        ctrl.rfWe       = 1'b1;
                        ctrl.aluOp      = mipsPkg::aluAdd;
                        ctrl.instrClass = mipsPkg::clsCal;
                        tuseRs          = 3'd1;
                        tuseRt          = 3'd1;
                        tnew            = 2'd2;
                    end
                    mipsPkg::opSubu: begin
                        ctrl.wrSel      = mipsPkg::wrRd;
                        ctrl.rfWe       = 1'b1;
                        ctrl.aluOp      = mipsPkg::aluSub;
                        ctrl.instrClass = mipsPkg::clsCal;
                        tuseRs          = 3'd1;
                        tuseRt          = 3'd1;
                        tnew            = 2'd2;
                    end
                    mipsPkg::opJr: begin
                        ctrl.npcOp      = mipsPkg::npcJr;
                        ctrl.instrClass = mipsPkg::clsJumpJr;
                        tuseRs          = 3'd0;  // Target needed in decode.
                    end
                    default: ;
                endcase
            end
            mipsPkg::opOri: begin
                ctrl.rfWe       = 1'b1;
                ctrl.bSel       = 1'b1;
                ctrl.aluOp      = mipsPkg::aluOr;
                ctrl.instrClass = mipsPkg::clsCal;
                tuseRs          = 3'd1;  // Rt is the destination.
                tnew            = 2'd2;
            end
            mipsPkg::opLui: begin
                ctrl.rfWe       = 1'b1;
                ctrl.bSel       = 1'b1;
                ctrl.aluOp      = mipsPkg::aluLui;
                ctrl.instrClass = mipsPkg::clsCal;
                tnew            = 2'd2;
            end
            mipsPkg::opLw: begin
                ctrl.wdSel      = mipsPkg::wdMem;
                ctrl.rfWe       = 1'b1;
                ctrl.extOp      = 1'b1;
                ctrl.bSel       = 1'b1;
                ctrl.aluOp      = mipsPkg::aluAdd;
                ctrl.instrClass = mipsPkg::clsLoad;
                tuseRs          = 3'd1;
                tnew            = mipsPkg::tnewMax;
            end
            mipsPkg::opSw: begin
                ctrl.extOp      = 1'b1;
                ctrl.bSel       = 1'b1;
                ctrl.aluOp      = mipsPkg::aluAdd;
                ctrl.dmWe       = 1'b1;
                ctrl.instrClass = mipsPkg::clsSave;
                tuseRs          = 3'd1;
                tuseRt          = 3'd2;  // Store data read in M.
            end
            mipsPkg::opBeq: begin
                ctrl.npcOp      = mipsPkg::npcBranch;
                ctrl.extOp      = 1'b1;
                ctrl.cmpOp      = mipsPkg::cmpEq;
                ctrl.instrClass = mipsPkg::clsCmpJump;
                tuseRs          = 3'd0;
                tuseRt          = 3'd0;
            end
            mipsPkg::opJ: begin
                ctrl.npcOp      = mipsPkg::npcJump;
                ctrl.instrClass = mipsPkg::clsJumpJJal;
            end
            mipsPkg::opJal: begin
                ctrl.npcOp      = mipsPkg::npcJump;
                ctrl.wrSel      = mipsPkg::wrRa;
                ctrl.wdSel      = mipsPkg::wdPc8;
                ctrl.rfWe       = 1'b1;
                ctrl.instrClass = mipsPkg::clsJumpJJal;
            end
            default: ;
        endcase
    end

    // Resolve the destination once here.
    always_comb begin
        case (ctrl.wrSel)
            mipsPkg::wrRt: dstReg = rt;
            mipsPkg::wrRd: dstReg = rd;
            mipsPkg::wrRa: dstReg = mipsPkg::regRa;
            default:       dstReg = mipsPkg::regZero;
        endcase
        if (!ctrl.rfWe) begin
            dstReg = mipsPkg::regZero;  // No write, never matches.
        end
    end

    assign hz = '{tuseRs: tuseRs, tuseRt: tuseRt, tnew: tnew, dstReg: dstReg};

endmodule

// File: src/writerTracker.sv
`timescale 1ns/10ps

module writerTracker (
    input  logic            clk,
    input  logic            rstN,
    input  mipsPkg::hazT    hz,
    input  logic            stall,
    output mipsPkg::writerT writerE,
    output mipsPkg::writerT writerM,
    output mipsPkg::writerT writerW
);

    mipsPkg::writerT enterE;

    // One stage older, tnew floored at zero.
    function automatic mipsPkg::writerT age(input mipsPkg::writerT w);
        mipsPkg::writerT aged;
        aged = w;
        if (w.tnew != 2'd0) begin
            aged.tnew = w.tnew - 2'd1;
        end
        return aged;
    endfunction

    always_comb begin
        if (stall) begin
            enterE = '0;  // Bubble.
        end else begin
            enterE = '{dstReg: hz.dstReg, tnew: hz.tnew};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            writerE <= '0;
            writerM <= '0;
            writerW <= '0;
        end else begin
            writerE <= enterE;
            writerM <= age(writerE);
            writerW <= age(writerM);
        end
    end

endmodule

// File: src/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit (
    input  logic [31:0]       instr,
    input  mipsPkg::hazT      hz,
    input  mipsPkg::writerT   writerE,
    input  mipsPkg::writerT   writerM,
    input  mipsPkg::writerT   writerW,
    output logic              stall,
    output mipsPkg::fwdSelE   fwdRs,
    output mipsPkg::fwdSelE   fwdRt
);

    logic [4:0] rs;
    logic [4:0] rt;

    assign rs = instr[25:21];
    assign rt = instr[20:16];

    // Result not ready in time for this operand.
    function automatic logic operandStall(
        input logic [4:0]      src,
        input logic [2:0]      tuse,
        input mipsPkg::writerT wE,
        input mipsPkg::writerT wM
    );
        logic hit;
        hit = 1'b0;
        if (tuse != mipsPkg::tuseNone && src != mipsPkg::regZero) begin
            if (wE.dstReg == src && {1'b0, wE.tnew} > tuse) begin
                hit = 1'b1;
            end
            if (wM.dstReg == src && {1'b0, wM.tnew} > tuse) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Nearest matching stage wins.
    function automatic mipsPkg::fwdSelE operandFwd(
        input logic [4:0]      src,
        input mipsPkg::writerT wE,
        input mipsPkg::writerT wM,
        input mipsPkg::writerT wW
    );
        mipsPkg::fwdSelE sel;
        sel = mipsPkg::fwdNone;
        if (src == mipsPkg::regZero) begin
            sel = mipsPkg::fwdNone;
        end else if (wE.dstReg == src) begin
            if (wE.tnew == 2'd0) sel = mipsPkg::fwdE;
        end else if (wM.dstReg == src) begin
            if (wM.tnew == 2'd0) sel = mipsPkg::fwdM;
        end else if (wW.dstReg == src) begin
            if (wW.tnew == 2'd0) sel = mipsPkg::fwdW;
        end
        return sel;
    endfunction

    assign stall = operandStall(rs, hz.tuseRs, writerE, writerM)
                 | operandStall(rt, hz.tuseRt, writerE, writerM);

    assign fwdRs = operandFwd(rs, writerE, writerM, writerW);
    assign fwdRt = operandFwd(rt, writerE, writerM, writerW);

endmodule

// File: src/decodeStage.sv
`timescale 1ns/10ps

module decodeStage (
    input  logic            clk,
    input  logic            rstN,
    input  logic [31:0]     instr,  // Held by fetch while stalled.
    output mipsPkg::ctrlT   ctrl,
    output logic            stall,
    output mipsPkg::fwdSelE fwdRs,
    output mipsPkg::fwdSelE fwdRt
);

    mipsPkg::hazT    hz;
    mipsPkg::writerT writerE;
    mipsPkg::writerT writerM;
    mipsPkg::writerT writerW;

    instrDecoder uDecoder (
        .instr (instr),
        .ctrl  (ctrl),
        .hz    (hz)
    );

    writerTracker uTracker (
        .clk     (clk),
        .rstN    (rstN),
        .hz      (hz),
        .stall   (stall),
        .writerE (writerE),
        .writerM (writerM),
        .writerW (writerW)
    );

    hazardUnit uHazard (
        .instr   (instr),
        .hz      (hz),
        .writerE (writerE),
        .writerM (writerM),
        .writerW (writerW),
        .stall   (stall),
        .fwdRs   (fwdRs),
        .fwdRt   (fwdRt)
    );

endmodule

// File: verif/tbDecodeStage.sv
`timescale 1ns/10ps

module tbDecodeStage;

    localparam int clkPeriod   = 4;
    localparam int resetCycles = 5;

    // One cycle of stimulus and expected response.
    typedef struct packed {
        logic [31:0] instr;
        logic        stall;
        logic [1:0]  fwdRs;
        logic [1:0]  fwdRt;
        logic        rfWe;
        logic [2:0]  aluOp;
        logic [1:0]  npcOp;
        logic [2:0]  instrClass;
        logic        dmWe;
    } vectorT;

    logic            clk;
    logic            rstN;
    logic [31:0]     instr;
    mipsPkg::ctrlT   ctrl;
    logic            stall;
    mipsPkg::fwdSelE fwdRs;
    mipsPkg::fwdSelE fwdRt;

    vectorT vectors[$];
    logic   loaded;

    decodeStage i_decodeStage (
        .clk   (clk),
        .rstN  (rstN),
        .instr (instr),
        .ctrl  (ctrl),
        .stall (stall),
        .fwdRs (fwdRs),
        .fwdRt (fwdRt)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Comment lines carry no hex and scan as zero fields.
    task automatic loadStimulus(output logic openOk, output int badLines);
        int               fd;
        int               code;
        int               fields;
        logic [8*160-1:0] lineBuf;
        logic [31:0]      fInstr;
        logic [31:0]      fStall;
        logic [31:0]      fFwdRs;
        logic [31:0]      fFwdRt;
        logic [31:0]      fRfWe;
        logic [31:0]      fAluOp;
        logic [31:0]      fNpcOp;
        logic [31:0]      fClass;
        logic [31:0]      fDmWe;
        vectorT           v;
        badLines = 0;
        fd = $fopen("verif/decodeStim.txt", "r");
        openOk = (fd != 0);
        if (openOk) begin
            while (!$feof(fd)) begin
                lineBuf = '0;
                code = $fgets(lineBuf, fd);
                if (code > 0) begin
                    fields = $sscanf(lineBuf, "%h %h %h %h %h %h %h %h %h", fInstr, fStall,
                                     fFwdRs, fFwdRt, fRfWe, fAluOp, fNpcOp, fClass, fDmWe);
                    if (fields == 9) begin
                        v.instr      = fInstr;
                        v.stall      = fStall[0];
                        v.fwdRs      = fFwdRs[1:0];
                        v.fwdRt      = fFwdRt[1:0];
                        v.rfWe       = fRfWe[0];
                        v.aluOp      = fAluOp[2:0];
                        v.npcOp      = fNpcOp[1:0];
                        v.instrClass = fClass[2:0];
                        v.dmWe       = fDmWe[0];
                        vectors.push_back(v);
                    end else if (fields > 0) begin
                        badLines++;  // Partial line.
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic compareField(input string name, input int idx,
                                input logic [31:0] expVal, input logic [31:0] actVal);
        assert (actVal === expVal) else begin
            $display("[ERROR] %s at vector %0d expected 0x%0h got 0x%0h",
                     name, idx, expVal, actVal);
            $display("Verification failed");
            $fatal(1, "Mismatch on %s.", name);
        end
    endtask

    task automatic checkOutputs(input vectorT exp, input int idx);
        compareField("stall", idx, 32'(exp.stall), 32'(stall));
        compareField("fwdRs", idx, 32'(exp.fwdRs), 32'(fwdRs));
        compareField("fwdRt", idx, 32'(exp.fwdRt), 32'(fwdRt));
        compareField("ctrl.rfWe", idx, 32'(exp.rfWe), 32'(ctrl.rfWe));
        compareField("ctrl.aluOp", idx, 32'(exp.aluOp), 32'(ctrl.aluOp));
        compareField("ctrl.npcOp", idx, 32'(exp.npcOp), 32'(ctrl.npcOp));
        compareField("ctrl.instrClass", idx, 32'(exp.instrClass), 32'(ctrl.instrClass));
        compareField("ctrl.dmWe", idx, 32'(exp.dmWe), 32'(ctrl.dmWe));
    endtask

    initial begin
        wait (loaded === 1'b1);
        #((vectors.size() + 20) * clkPeriod);
        $display("Timeout, the run did not reach the end of the stimulus in time.");
        $display("Verification failed");
        $fatal(1, "Watchdog expired.");
    end

    initial begin
        logic openOk;
        int   badLines;
        rstN   = 1'b0;
        instr  = '0;
        loaded = 1'b0;
        loadStimulus(openOk, badLines);
        if (!openOk || badLines != 0 || vectors.size() == 0) begin
            $display("The stimulus file verif/decodeStim.txt is missing, empty or malformed.");
            $display("Verification failed");
            $fatal(1, "No usable stimulus.");
        end else begin
            loaded = 1'b1;
            repeat (resetCycles) @(posedge clk);
            rstN <= 1'b1;
            for (int i = 0; i < vectors.size(); i++) begin
                @(posedge clk);
                if (i > 0 && vectors[i - 1].stall) begin
                    // Fetch holds the stalled word.
                    assert (vectors[i].instr === instr) else begin
                        $display("Stimulus vector %0d changes the word while decode is stalled.",
                                 i);
                        $display("Verification failed");
                        $fatal(1, "Bad stimulus.");
                    end
                end else begin
                    instr <= vectors[i].instr;
                end
                @(negedge clk);  // Outputs settled.
                checkOutputs(vectors[i], i);
            end
            $display("Verification passed");
            $finish;
        end
    end

endmodule

// File: verif/decodeStim.txt
// Columns are instr stall fwdRs fwdRt rfWe aluOp npcOp instrClass dmWe in hex.
// One line per cycle after reset. A stalled word is listed again on the next line.
// Decode table right after reset.
01095821 0 0 0 1 1 0 1 0
01AE6023 0 0 0 1 2 0 1 0
36301234 0 0 0 1 3 0 1 0
3C12ABCD 0 0 0 1 4 0 1 0
AE930008 0 0 0 0 1 0 3 1
08000100 0 0 0 0 0 2 5 0
FC000000 0 0 0 0 0 0 0 0
00000000 0 0 0 0 0 0 0 0
// Load then dependent addu. W still shows tnew 1 after the stall.
8EA80000 0 0 0 1 1 0 2 0
01164821 1 0 0 1 1 0 1 0
01164821 1 0 0 1 1 0 1 0
01164821 0 0 0 1 1 0 1 0
00000000 0 0 0 0 0 0 0 0
00000000 0 0 0 0 0 0 0 0
00000000 0 0 0 0 0 0 0 0
// ori then two readers of $t1.
34090055 0 0 0 1 3 0 1 0
01375023 1 0 0 1 2 0 1 0
01375023 0 0 0 1 2 0 1 0
01298821 0 3 3 1 1 0 1 0
00000000 0 0 0 0 0 0 0 0
00000000 0 0 0 0 0 0 0 0
00000000 0 0 0 0 0 0 0 0
// Branch on a fresh ALU result.
02115021 0 0 0 1 1 0 1 0
11400003 1 0 0 0 0 1 4 0
11400003 1 0 0 0 0 1 4 0
11400003 0 3 0 0 0 1 4 0
// jal then jr on $ra from each stage.
0C000040 0 0 0 1 0 2 5 0
03E00008 0 1 0 0 0 3 6 0
03E00008 0 2 0 0 0 3 6 0
03E00008 0 3 0 0 0 3 6 0
// Register 0 never matches.
01090021 0 0 0 1 1 0 1 0
10000001 0 0 0 0 0 1 4 0
00005821 0 0 0 1 1 0 1 0
00000000 0 0 0 0 0 0 0 0

// File: build.f
src/mipsPkg.sv
src/instrDecoder.sv
src/writerTracker.sv
src/hazardUnit.sv
src/decodeStage.sv
verif/tbDecodeStage.sv

// File: Bender.yml
package:
  name: decodeStage

sources:
  - src/mipsPkg.sv
  - src/instrDecoder.sv
  - src/writerTracker.sv
  - src/hazardUnit.sv
  - src/decodeStage.sv
  - target: test
    files:
      - verif/tbDecodeStage.sv
